// ==== hw/forthJumpPkg.sv ====
`default_nettype none

package forthJumpPkg;

	localparam int INSTR_WIDTH = 16;

	typedef logic [INSTR_WIDTH-1:0] dataWord;

	// ==============================
	// group and field encodings
	// ==============================
	localparam logic [1:0] GROUP_LOAD = 2'b01;
	localparam logic [1:0] GROUP_JUMP = 2'b11;

	localparam logic [1:0] CC_SELECT_Z = 2'b00;
	localparam logic [1:0] CC_SELECT_C = 2'b01;
	localparam logic [1:0] CC_SELECT_S = 2'b10;
	localparam logic [1:0] CC_SELECT_P = 2'b11;

	localparam logic [1:0] MODE_ABS_REG = 2'b00;
	localparam logic [1:0] MODE_REL_REG = 2'b01;
	localparam logic [1:0] MODE_REL_IMM = 2'b10; // 2'b11 behaves as abs.

	localparam logic [2:0] LINK_REG = 3'd7;

	// jump group layout, msb first.
	typedef struct packed {
		logic [1:0] group;
		logic       ccApply;
		logic       ccInvert;
		logic [1:0] ccSelect;
		logic [1:0] jumpMode;
		logic       link;
		logic [6:0] arg;      // word offset, or register in [2:0].
	} jumpInstr;

	typedef struct packed {
		logic [1:0] group;
		logic [2:0] spare;
		logic [2:0] regSel;
		logic [7:0] imm;
	} loadInstr;

	typedef struct packed {
		logic zero;
		logic carry;
		logic sign;
		logic parity;
	} ccFlags;

	typedef struct packed {
		dataWord pc;
		dataWord instr;
	} fetchPacket;

	typedef struct packed {
		dataWord pc;
		dataWord instr;
		logic    taken;
		dataWord nextPc;
	} retireInfo;

endpackage

`default_nettype wire

// ==== hw/instructionFetch.sv ====
`default_nettype none

module instructionFetch #(
	parameter int queueDepth = 4,
	parameter logic [15:0] resetVector = 16'h0000,
	localparam int countWidth = $clog2(queueDepth) + 1
) (
	input  logic                     CLK,
	input  logic                     rst,
	output logic                     imemRead,
	output logic [15:0]              imemAddr,
	input  logic [15:0]              imemData,
	output forthJumpPkg::fetchPacket pkt,
	output logic                     pktValid,
	input  logic                     pktReady,
	input  logic [countWidth-1:0]    count,
	input  logic                     redirect,
	input  logic [15:0]              redirectPc
);

	logic [15:0] pc;
	logic [15:0] pendPc;
	logic pending;
	logic active;
	logic [countWidth:0] slotsUsed;
	logic slotFree;

	// ==============================
	// read request
	// ==============================
	// queued words plus the read still in flight.
	assign slotsUsed = {1'b0, count} + (countWidth + 1)'(pending);
	assign slotFree = slotsUsed < (countWidth + 1)'(queueDepth);

	// a response that cannot be taken blocks the next read.
	assign imemRead = active && slotFree && !redirect && (!pending || pktReady);
	assign imemAddr = pc;

	// ==============================
	// response to packet
	// ==============================
	assign pkt.pc = pendPc;
	assign pkt.instr = imemData;
	assign pktValid = pending && !redirect; // stale word dropped on redirect.

	always_ff @(posedge CLK) begin
		if (rst) begin
			active <= 1'b0;
			pending <= 1'b0;
			pc <= resetVector;
		end else begin
			active <= 1'b1;
			pending <= imemRead || (pending && !pktReady && !redirect);
			if (redirect) begin
				pc <= redirectPc;
			end else if (imemRead) begin
				pc <= pc + 16'd2;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (imemRead) begin
			pendPc <= pc;
		end
	end

endmodule

`default_nettype wire

// ==== hw/fetchQueue.sv ====
`default_nettype none

module fetchQueue #(
	parameter type itemType = logic [31:0],
	parameter int queueDepth = 4,
	localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1,
	localparam int countWidth = $clog2(queueDepth) + 1
) (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic                  flush,
	input  itemType               inData,
	input  logic                  inValid,
	output logic                  inReady,
	output itemType               outData,
	output logic                  outValid,
	input  logic                  outReady,
	output logic [countWidth-1:0] count
);

	itemType mem [queueDepth];
	logic [ptrWidth-1:0] rdPtr;
	logic [ptrWidth-1:0] wrPtr;
	logic push;
	logic pop;

	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] p);
		return (p == ptrWidth'(queueDepth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign inReady = count < countWidth'(queueDepth);
	assign outValid = count != '0;
	assign outData = mem[rdPtr];

	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	always_ff @(posedge CLK) begin
		if (rst || flush) begin // flush wins over a push.
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push) wrPtr <= nextPtr(wrPtr);
			if (pop) rdPtr <= nextPtr(rdPtr);
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (push && !flush) begin
			mem[wrPtr] <= inData;
		end
	end

endmodule

`default_nettype wire

// ==== hw/jumpExecute.sv ====
`default_nettype none

module jumpExecute (
	input  logic                     CLK,
	input  logic                     rst,
	input  forthJumpPkg::fetchPacket head,
	input  logic                     headValid,
	output logic                     headReady,
	input  forthJumpPkg::ccFlags     flags,
	output forthJumpPkg::retireInfo  retire,
	output logic                     retireValid,
	input  logic                     retireReady,
	output logic                     redirect,
	output logic [15:0]              redirectPc
);

	forthJumpPkg::jumpInstr jmp;
	forthJumpPkg::loadInstr ld;
	forthJumpPkg::dataWord regs [8];
	forthJumpPkg::dataWord regVal;
	forthJumpPkg::dataWord target;
	forthJumpPkg::dataWord seqPc;
	logic isJump;
	logic isLoad;
	logic flagSel;
	logic taken;
	logic fire;

	// ==============================
	// decode
	// ==============================
	assign jmp = head.instr;
	assign ld = head.instr;
	assign isJump = jmp.group == forthJumpPkg::GROUP_JUMP;
	assign isLoad = ld.group == forthJumpPkg::GROUP_LOAD;

	assign regVal = regs[jmp.arg[2:0]];
	assign seqPc = head.pc + 16'd2;

	always_comb begin
		unique case (jmp.ccSelect)
			forthJumpPkg::CC_SELECT_Z: flagSel = flags.zero;
			forthJumpPkg::CC_SELECT_C: flagSel = flags.carry;
			forthJumpPkg::CC_SELECT_S: flagSel = flags.sign;
			forthJumpPkg::CC_SELECT_P: flagSel = flags.parity;
		endcase
	end

	// unconditional when ccApply is clear.
	assign taken = isJump && (!jmp.ccApply || (flagSel ^ jmp.ccInvert));

	always_comb begin
		case (jmp.jumpMode)
			forthJumpPkg::MODE_ABS_REG: target = regVal;
			forthJumpPkg::MODE_REL_REG: target = head.pc + regVal;
			forthJumpPkg::MODE_REL_IMM: target = head.pc + {{8{jmp.arg[6]}}, jmp.arg, 1'b0};
			default:                    target = regVal;
		endcase
	end

	// ==============================
	// retire and redirect
	// ==============================
	assign headReady = retireReady;
	assign retireValid = headValid;
	assign fire = headValid && retireReady;

	assign retire.pc = head.pc;
	assign retire.instr = head.instr;
	assign retire.taken = taken;
	assign retire.nextPc = taken ? target : seqPc;

	assign redirect = fire && taken; // one cycle per taken jump.
	assign redirectPc = target;

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (fire && isLoad) begin
			regs[ld.regSel] <= {8'h00, ld.imm};
		end else if (fire && taken && jmp.link) begin
			regs[forthJumpPkg::LINK_REG] <= seqPc; // return address.
		end
	end

endmodule

`default_nettype wire

// ==== hw/forthJumpTop.sv ====
`default_nettype none

module forthJumpTop #(
	parameter int queueDepth = 4,
	parameter logic [15:0] resetVector = 16'h0000,
	localparam int countWidth = $clog2(queueDepth) + 1
) (
	input  logic                    CLK,
	input  logic                    rst,
	output logic                    imemRead,
	output logic [15:0]             imemAddr,
	input  logic [15:0]             imemData,
	input  forthJumpPkg::ccFlags    flags,
	output forthJumpPkg::retireInfo retire,
	output logic                    retireValid,
	input  logic                    retireReady
);

	forthJumpPkg::fetchPacket fetchPkt;
	forthJumpPkg::fetchPacket headPkt;
	logic fetchValid;
	logic fetchReady;
	logic headValid;
	logic headReady;
	logic [countWidth-1:0] count;
	logic redirect;
	logic [15:0] redirectPc;

	instructionFetch #(
		.queueDepth(queueDepth),
		.resetVector(resetVector)
	) fetch (
		.CLK(CLK),
		.rst(rst),
		.imemRead(imemRead),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.pkt(fetchPkt),
		.pktValid(fetchValid),
		.pktReady(fetchReady),
		.count(count),
		.redirect(redirect),
		.redirectPc(redirectPc)
	);

	fetchQueue #(
		.itemType(forthJumpPkg::fetchPacket),
		.queueDepth(queueDepth)
	) queue (
		.CLK(CLK),
		.rst(rst),
		.flush(redirect),
		.inData(fetchPkt),
		.inValid(fetchValid),
		.inReady(fetchReady),
		.outData(headPkt),
		.outValid(headValid),
		.outReady(headReady),
		.count(count)
	);

	jumpExecute execute (
		.CLK(CLK),
		.rst(rst),
		.head(headPkt),
		.headValid(headValid),
		.headReady(headReady),
		.flags(flags),
		.retire(retire),
		.retireValid(retireValid),
		.retireReady(retireReady),
		.redirect(redirect),
		.redirectPc(redirectPc)
	);

endmodule

`default_nettype wire

// ==== sim/forthJump_asserts.sv ====
`default_nettype none

module forthJumpAsserts (
	input logic                    CLK,
	input logic                    rst,
	input logic                    imemRead,
	input logic [15:0]             imemAddr,
	input forthJumpPkg::retireInfo retire,
	input logic                    retireValid,
	input logic                    retireReady,
	input logic                    redirect
);

	timeunit 1ns;
	timeprecision 100ps;

	// ==============================
	// handshake and redirect
	// ==============================
	stallHold: assert property (@(posedge CLK) disable iff (rst)
		retireValid && !retireReady |=> retireValid && $stable(retire))
		else $error("retire changed while stalled");

	redirectPulse: assert property (@(posedge CLK) disable iff (rst) redirect |=> !redirect)
		else $error("redirect held longer than one cycle");

	// stale words must not reach the head.
	redirectFlush: assert property (@(posedge CLK) disable iff (rst) redirect |=> !retireValid)
		else $error("fetched words survived a redirect");

	redirectRestart: assert property (@(posedge CLK) disable iff (rst)
		redirect |=> imemRead && imemAddr == $past(retire.nextPc))
		else $error("target read not issued after redirect");

	// registers are cleared one edge into reset.
	resetQuiet: assert property (@(posedge CLK)
		rst |=> !imemRead && !retireValid && !redirect)
		else $error("outputs active after a reset cycle");

endmodule

bind forthJumpTop forthJumpAsserts checks (
	.CLK(CLK),
	.rst(rst),
	.imemRead(imemRead),
	.imemAddr(imemAddr),
	.retire(retire),
	.retireValid(retireValid),
	.retireReady(retireReady),
	.redirect(redirect)
);

`default_nettype wire

// ==== sim/forthJumpTb.sv ====
`default_nettype none

module forthJumpTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCycles = 5;
	localparam int progLen = 19;
	localparam int watchdogNs = progLen * 4 * 8 + resetCycles * 4;
	localparam logic [15:0] haltPc = 16'h0060;
	localparam logic [1:0] selZ = forthJumpPkg::CC_SELECT_Z;
	localparam logic [1:0] selC = forthJumpPkg::CC_SELECT_C;
	localparam logic [1:0] selS = forthJumpPkg::CC_SELECT_S;
	localparam logic [1:0] selP = forthJumpPkg::CC_SELECT_P;
	localparam logic [1:0] absReg = forthJumpPkg::MODE_ABS_REG;
	localparam logic [1:0] relReg = forthJumpPkg::MODE_REL_REG;
	localparam logic [1:0] relImm = forthJumpPkg::MODE_REL_IMM;

	logic CLK;
	logic rst;
	logic imemRead;
	logic [15:0] imemAddr;
	logic [15:0] imemData;
	forthJumpPkg::ccFlags flags;
	forthJumpPkg::retireInfo retire;
	logic retireValid;
	logic retireReady;

	logic [15:0] imem [256];
	forthJumpPkg::ccFlags flagTab [256];
	string nameTab [256];
	logic [15:0] modelRegs [8];
	logic [15:0] modelPc;
	logic [15:0] respWord;
	logic respDue;
	logic [31:0] lcgState;
	logic done;
	int errCount;
	int retireCount;

	forthJumpTop #(.queueDepth(4), .resetVector(16'h0000)) dut (.*);

	always #2 CLK = ~CLK;

	function automatic logic [15:0] encodeLoad(input logic [2:0] r, input logic [7:0] imm);
		return {forthJumpPkg::GROUP_LOAD, 3'b000, r, imm};
	endfunction

	function automatic logic [15:0] encodeJump(input logic apply, input logic inv,
			input logic [1:0] sel, input logic [1:0] mode, input logic link, input logic [6:0] arg);
		return {forthJumpPkg::GROUP_JUMP, apply, inv, sel, mode, link, arg};
	endfunction

	function automatic logic nextReady();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[29:28] != 2'b00; // ready about three cycles in four.
	endfunction

	task automatic place(input logic [15:0] pc, input logic [15:0] instr,
			input forthJumpPkg::ccFlags f, input string name);
		imem[pc[8:1]] = instr;
		flagTab[pc[8:1]] = f;
		nameTab[pc[8:1]] = name;
	endtask

	// ==============================
	// program, flags are z c s p
	// ==============================
	task automatic loadProgram();
		for (int i = 0; i < 256; i++) begin
			imem[i] = {2'b00, 14'(i * 37 + 5)}; // no-op filler.
			flagTab[i] = '0;
			nameTab[i] = "filler";
		end
		place(16'h00, encodeLoad(3'd3, 8'h40), 4'b0000, "load r3");
		place(16'h02, encodeLoad(3'd2, 8'h10), 4'b0000, "load r2");
		place(16'h04, encodeLoad(3'd1, 8'h20), 4'b0000, "load r1");
		place(16'h06, encodeJump(1'b0, 1'b0, selZ, absReg, 1'b0, 7'd1), 4'b0000, "abs via r1");
		place(16'h20, encodeJump(1'b1, 1'b0, selZ, relImm, 1'b0, 7'd4), 4'b1000, "z taken");
		place(16'h28, encodeJump(1'b1, 1'b1, selZ, relImm, 1'b0, 7'd8), 4'b1000, "z inv not taken");
		place(16'h2a, encodeJump(1'b1, 1'b0, selC, relReg, 1'b0, 7'd2), 4'b0100, "c taken rel reg");
		place(16'h3a, encodeJump(1'b1, 1'b1, selC, relImm, 1'b0, 7'h7b), 4'b0000, "c inv back");
		place(16'h30, encodeJump(1'b1, 1'b0, selS, relImm, 1'b0, 7'd6), 4'b0000, "s not taken");
		place(16'h32, encodeJump(1'b1, 1'b1, selS, relImm, 1'b0, 7'd6), 4'b0010, "s inv not taken");
		place(16'h34, encodeJump(1'b1, 1'b0, selP, relImm, 1'b0, 7'h10), 4'b0001, "p taken");
		place(16'h54, encodeJump(1'b1, 1'b1, selP, absReg, 1'b0, 7'd3), 4'b0001, "p inv not taken");
		place(16'h56, encodeJump(1'b1, 1'b0, selC, absReg, 1'b0, 7'd3), 4'b1011, "c not taken");
		place(16'h58, encodeJump(1'b1, 1'b1, selS, relImm, 1'b0, 7'd2), 4'b0000, "s inv taken");
		place(16'h5c, encodeJump(1'b0, 1'b0, selZ, relImm, 1'b1, 7'h10), 4'b0000, "linked call");
		place(16'h5e, encodeLoad(3'd4, 8'h99), 4'b0000, "load after return");
		place(16'h60, encodeJump(1'b0, 1'b0, selZ, relImm, 1'b0, 7'd0), 4'b0000, "halt");
		place(16'h7c, encodeLoad(3'd5, 8'h0c), 4'b0000, "load in callee");
		place(16'h7e, encodeJump(1'b0, 1'b0, selZ, absReg, 1'b0, 7'd7), 4'b0000, "return via r7");
	endtask

	// walks one instruction at modelPc.
	task automatic predictRetire(output forthJumpPkg::retireInfo e);
		logic [15:0] instr;
		logic [15:0] tgt;
		forthJumpPkg::ccFlags f;
		logic flag;
		int off;
		instr = imem[modelPc[8:1]];
		f = flagTab[modelPc[8:1]];
		e.pc = modelPc;
		e.instr = instr;
		e.taken = 1'b0;
		e.nextPc = modelPc + 16'd2;
		if (instr[15:14] == forthJumpPkg::GROUP_JUMP) begin
			case (instr[11:10])
				selZ: flag = f.zero;
				selC: flag = f.carry;
				selS: flag = f.sign;
				default: flag = f.parity;
			endcase
			off = int'($signed(instr[6:0]));
			if (instr[9:8] == relReg) tgt = modelPc + modelRegs[instr[2:0]];
			else if (instr[9:8] == relImm) tgt = modelPc + 16'(2 * off);
			else tgt = modelRegs[instr[2:0]];
			e.taken = !instr[13] || (flag != instr[12]);
			if (e.taken) e.nextPc = tgt;
			if (e.taken && instr[7]) modelRegs[7] = modelPc + 16'd2;
		end else if (instr[15:14] == forthJumpPkg::GROUP_LOAD) begin
			modelRegs[instr[10:8]] = {8'h00, instr[7:0]};
		end
		modelPc = e.nextPc;
	endtask

	// ==============================
	// stimulus
	// ==============================
	initial begin
		CLK = 1'b0;
		rst = 1'b1;
		retireReady = 1'b0;
		flags = '0;
		imemData = '0;
		lcgState = 32'hda78;
		modelPc = 16'h0000;
		done = 1'b0;
		errCount = 0;
		retireCount = 0;
		for (int i = 0; i < 8; i++) modelRegs[i] = '0;
		loadProgram();
		repeat (resetCycles) @(posedge CLK);
		#1 rst = 1'b0;
		forever begin
			@(posedge CLK);
			#1;
			if (respDue) imemData = respWord;
			retireReady = nextReady();
			flags = flagTab[retire.pc[8:1]]; // flags follow the head instruction.
		end
	end

	// memory answers one cycle after the read.
	always @(negedge CLK) begin
		respDue = imemRead;
		respWord = imem[imemAddr[8:1]];
	end

	always @(negedge CLK) begin
		forthJumpPkg::retireInfo want;
		string name;
		if (!rst && !done && retireValid && retireReady) begin
			name = nameTab[modelPc[8:1]];
			predictRetire(want);
			retireCount++;
			assert (retire == want) else begin
				errCount++;
				$display("Mismatch %s: expected pc/instr/taken/next %h/%h/%b/%h, actual %h/%h/%b/%h",
					name, want.pc, want.instr, want.taken, want.nextPc,
					retire.pc, retire.instr, retire.taken, retire.nextPc);
			end
			if (want.pc == haltPc) done = 1'b1;
		end
	end

	initial begin
		wait (done);
		@(posedge CLK);
		$display("summary: %0d retires checked, %0d mismatches", retireCount, errCount);
		if (errCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("timeout: halt not retired within %0d ns", watchdogNs);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== forthJump.f ====
hw/forthJumpPkg.sv
hw/instructionFetch.sv
hw/fetchQueue.sv
hw/jumpExecute.sv
hw/forthJumpTop.sv
sim/forthJump_asserts.sv
sim/forthJumpTb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the forthJump testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module forthJumpTb -f forthJump.f -o forthJumpSim; then
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/forthJumpSim > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error"
	exit 1
fi

cat "$LOG"
if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
exit 0
